//--- files.f
hdl/bpu_pkg.sv
hdl/bpu_update_if.sv
hdl/inst_predecode.sv
hdl/bimodal_table.sv
hdl/btb.sv
hdl/return_stack.sv
hdl/next_pc_select.sv
hdl/bpu.sv
tb/tb_clock_gen.sv
tb/bpu_checker.sv
tb/bpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the bpu testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f files.f --top-module bpu_tb -o bpu_sim; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/bpu_sim)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

//--- tb/bpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_tb;

    localparam int clk_period_ns    = 8;
    localparam int reset_cycles     = 2;
    localparam int wd_margin_cycles = 20;
    localparam logic [31:0] nop_w = 32'h0000_0013;   // addi x0, x0, 0
    localparam logic [31:0] lw_w  = 32'h0002_a303;   // lw t1, 0(t0)

    typedef struct packed {
        logic [31:0] if_pc;
        logic [31:0] if_inst;
        logic        ex_valid;
        logic        ex_taken;
        logic [31:0] ex_pc;
        logic [31:0] ex_target;
        logic [31:0] ex_inst;
        logic        push;
        logic [31:0] push_data;
        logic        stall;
        logic        exp_bon;
        logic        exp_res;
        logic [31:0] exp_pc;
    } row_t;

    logic        clk;
    logic        rst;
    logic [31:0] if_pc, if_inst;
    logic        ex_valid, ex_taken;
    logic [31:0] ex_pc, ex_target, ex_inst;
    logic        push_valid;
    logic [31:0] push_data;
    logic        stall;
    logic        branch_or_not, pdt_res;
    logic [31:0] pdt_pc;

    row_t rows[$];
    row_t cur;
    row_t act_row;
    logic check_en;
    int   row_idx;
    int   pass_cnt, fail_cnt;
    logic table_ready = 1'b0;

    tb_clock_gen #(.period_ns(clk_period_ns), .reset_cycles(reset_cycles)) clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    bpu bpu_inst (
        .clk                 (clk),
        .rst                 (rst),
        .if_pc_i             (if_pc),
        .if_inst_i           (if_inst),
        .ex_branch_valid_i   (ex_valid),
        .ex_branch_taken_i   (ex_taken),
        .ex_pc_i             (ex_pc),
        .ex_target_i         (ex_target),
        .ex_inst_i           (ex_inst),
        .id_ras_push_valid_i (push_valid),
        .id_ras_push_data_i  (push_data),
        .ex_stall_valid_i    (stall),
        .branch_or_not_o     (branch_or_not),
        .pdt_pc_o            (pdt_pc),
        .pdt_res_o           (pdt_res)
    );

    bpu_checker check_inst (
        .clk        (clk),
        .check_i    (check_en),
        .row_i      (row_idx),
        .exp_bon_i  (act_row.exp_bon),
        .exp_res_i  (act_row.exp_res),
        .exp_pc_i   (act_row.exp_pc),
        .act_bon_i  (branch_or_not),
        .act_res_i  (pdt_res),
        .act_pc_i   (pdt_pc),
        .pass_cnt_o (pass_cnt),
        .fail_cnt_o (fail_cnt)
    );

    // instruction builders, straight from the isa field layout
    function automatic logic [31:0] branch_word(input int off);
        logic [31:0] v;
        v = off;
        return {v[12], v[10:5], 5'd2, 5'd1, 3'b000, v[4:1], v[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input int off);
        logic [31:0] v;
        v = off;
        return {v[20], v[10:1], v[11], v[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input int off);
        logic [31:0] v;
        v = off;
        return {v[11:0], rs1, 3'b000, rd, 7'b1100111};
    endfunction

    task automatic start_row(input logic [31:0] pc, input logic [31:0] inst,
                             input logic bon, input logic res, input logic [31:0] npc);
        cur         = '0;
        cur.if_pc   = pc;
        cur.if_inst = inst;
        cur.ex_inst = nop_w;
        cur.exp_bon = bon;
        cur.exp_res = res;
        cur.exp_pc  = npc;
    endtask

    task automatic add_resolve(input logic taken, input logic [31:0] pc,
                               input logic [31:0] tgt, input logic [31:0] inst);
        cur.ex_valid  = 1'b1;
        cur.ex_taken  = taken;
        cur.ex_pc     = pc;
        cur.ex_target = tgt;
        cur.ex_inst   = inst;
    endtask

    task automatic add_push(input logic [31:0] data);
        cur.push      = 1'b1;
        cur.push_data = data;
    endtask

    task automatic mark_stall();
        cur.stall = 1'b1;
    endtask

    task automatic commit_row();
        rows.push_back(cur);
    endtask

    task automatic build_table();
        logic [31:0] br;
        logic [31:0] jal_a;
        logic [31:0] ret_ra;
        br     = branch_word(32'h40);
        jal_a  = jal_word(5'd1, 32'h100);
        ret_ra = jalr_word(5'd0, 5'd1, 0);
        // after reset, nothing trained
        start_row(32'h1000, nop_w, 1'b0, 1'b0, 32'h1004);
        commit_row();
        start_row(32'h1004, lw_w, 1'b0, 1'b0, 32'h1008);
        commit_row();
        start_row(32'h1100, br, 1'b1, 1'b0, 32'h1104);
        commit_row();
        start_row(32'h1104, jalr_word(5'd1, 5'd10, 0), 1'b1, 1'b0, 32'h1108);
        commit_row();
        // bimodal counter at 0x1200 walks 1 -> 2 -> 3 -> 3 -> 2 -> 1 -> 0 -> 0
        start_row(32'h1200, br, 1'b1, 1'b0, 32'h1204);
        add_resolve(1'b1, 32'h1200, 32'h1240, br);
        commit_row();
        start_row(32'h1200, br, 1'b1, 1'b1, 32'h1240);
        add_resolve(1'b1, 32'h1200, 32'h1240, br);
        commit_row();
        // same counter and btb slot, other tag, so target from the b offset
        start_row(32'h1600, branch_word(-32), 1'b1, 1'b1, 32'h15e0);
        add_resolve(1'b1, 32'h1200, 32'h1240, br);
        commit_row();
        start_row(32'h1200, br, 1'b1, 1'b1, 32'h1240);
        add_resolve(1'b0, 32'h1200, 32'h1204, br);
        commit_row();
        start_row(32'h1200, br, 1'b1, 1'b1, 32'h1240);
        add_resolve(1'b0, 32'h1200, 32'h1204, br);
        commit_row();
        start_row(32'h1200, br, 1'b1, 1'b0, 32'h1204);
        add_resolve(1'b0, 32'h1200, 32'h1204, br);
        commit_row();
        start_row(32'h1200, br, 1'b1, 1'b0, 32'h1204);
        add_resolve(1'b0, 32'h1200, 32'h1204, br);
        commit_row();
        start_row(32'h1200, br, 1'b1, 1'b0, 32'h1204);
        commit_row();
        // jal targets
        start_row(32'h2000, jal_a, 1'b1, 1'b1, 32'h2100);
        commit_row();
        start_row(32'h2004, nop_w, 1'b0, 1'b0, 32'h2008);
        add_resolve(1'b1, 32'h2000, 32'h3000, jal_a);
        commit_row();
        start_row(32'h2000, jal_a, 1'b1, 1'b1, 32'h3000);
        commit_row();
        start_row(32'h2400, jal_a, 1'b1, 1'b1, 32'h2500);
        commit_row();
        start_row(32'h2800, jal_word(5'd0, -2048), 1'b1, 1'b1, 32'h2000);
        commit_row();
        // return prediction
        start_row(32'h3040, ret_ra, 1'b1, 1'b0, 32'h3044);
        commit_row();
        start_row(32'h3100, nop_w, 1'b0, 1'b0, 32'h3104);
        add_push(32'h4004);
        commit_row();
        start_row(32'h3104, nop_w, 1'b0, 1'b0, 32'h3108);
        add_push(32'h5008);
        commit_row();
        start_row(32'h3040, ret_ra, 1'b1, 1'b1, 32'h5008);
        commit_row();
        start_row(32'h3108, nop_w, 1'b0, 1'b0, 32'h310c);
        add_resolve(1'b1, 32'h3040, 32'h5008, ret_ra);
        commit_row();
        start_row(32'h3040, ret_ra, 1'b1, 1'b1, 32'h4004);
        commit_row();
        start_row(32'h310c, nop_w, 1'b0, 1'b0, 32'h3110);
        add_resolve(1'b1, 32'h3040, 32'h4004, ret_ra);
        commit_row();
        start_row(32'h3040, jalr_word(5'd0, 5'd5, 0), 1'b1, 1'b0, 32'h3044);
        commit_row();
        // stall, same-cycle pop and push, overflow
        start_row(32'h3200, nop_w, 1'b0, 1'b0, 32'h3204);
        add_push(32'h6000);
        mark_stall();
        commit_row();
        start_row(32'h3040, ret_ra, 1'b1, 1'b0, 32'h3044);
        commit_row();
        start_row(32'h3204, nop_w, 1'b0, 1'b0, 32'h3208);
        add_push(32'h6100);
        commit_row();
        start_row(32'h3208, nop_w, 1'b0, 1'b0, 32'h320c);
        add_push(32'h6200);
        add_resolve(1'b1, 32'h3040, 32'h6100, ret_ra);
        commit_row();
        start_row(32'h3040, ret_ra, 1'b1, 1'b1, 32'h6200);
        commit_row();
        start_row(32'h320c, nop_w, 1'b0, 1'b0, 32'h3210);
        add_resolve(1'b1, 32'h3040, 32'h6200, ret_ra);
        commit_row();
        for (int k = 0; k < 33; k++) begin
            start_row(32'h8000 + 4 * k, nop_w, 1'b0, 1'b0, 32'h8004 + 4 * k);
            add_push(32'h7000 + 4 * k);   // 33rd push lands on a full stack
            commit_row();
        end
        start_row(32'h3040, ret_ra, 1'b1, 1'b1, 32'h707c);
        commit_row();
        start_row(32'h3300, nop_w, 1'b0, 1'b0, 32'h3304);
        add_resolve(1'b1, 32'h3040, 32'h707c, ret_ra);
        commit_row();
        start_row(32'h3040, ret_ra, 1'b1, 1'b1, 32'h7078);
        commit_row();
    endtask

    task automatic apply_row(input row_t r);
        if_pc      = r.if_pc;
        if_inst    = r.if_inst;
        ex_valid   = r.ex_valid;
        ex_taken   = r.ex_taken;
        ex_pc      = r.ex_pc;
        ex_target  = r.ex_target;
        ex_inst    = r.ex_inst;
        push_valid = r.push;
        push_data  = r.push_data;
        stall      = r.stall;
        act_row    = r;
    endtask

    initial begin
        check_en = 1'b0;
        row_idx  = 0;
        start_row(32'h0, nop_w, 1'b0, 1'b0, 32'h4);
        apply_row(cur);
        build_table();
        table_ready = 1'b1;
        @(negedge rst);
        foreach (rows[i]) begin
            @(negedge clk);
            apply_row(rows[i]);
            row_idx  = i;
            check_en = 1'b1;
        end
        @(negedge clk);
        check_en = 1'b0;
        start_row(32'h0, nop_w, 1'b0, 1'b0, 32'h4);
        apply_row(cur);
        if (pass_cnt + fail_cnt != rows.size()) begin
            $display("checker compared %0d of %0d rows", pass_cnt + fail_cnt, rows.size());
        end
        $display("%0d rows, %0d passed, %0d failed", rows.size(), pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == rows.size()) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // limit scales with the table length
    initial begin
        wait (table_ready);
        #((rows.size() + reset_cycles + wd_margin_cycles) * clk_period_ns);
        $display("timeout: the table did not finish within %0d cycles",
                 rows.size() + reset_cycles + wd_margin_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/bpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_checker (
    input  logic        clk,
    input  logic        check_i,
    input  int          row_i,
    input  logic        exp_bon_i,
    input  logic        exp_res_i,
    input  logic [31:0] exp_pc_i,
    input  logic        act_bon_i,
    input  logic        act_res_i,
    input  logic [31:0] act_pc_i,
    output int          pass_cnt_o,
    output int          fail_cnt_o
);

    int n_pass = 0;
    int n_fail = 0;

    assign pass_cnt_o = n_pass;
    assign fail_cnt_o = n_fail;

    // outputs are combinational, still settled from the falling-edge drive
    always @(posedge clk) begin
        if (check_i) begin : compare
            logic ok;
            ok = 1'b1;
            if (act_bon_i !== exp_bon_i) begin
                $display("ERROR at %0d ns: branch_or_not_o expected %b actual %b",
                         $time, exp_bon_i, act_bon_i);
                ok = 1'b0;
            end
            if (act_res_i !== exp_res_i) begin
                $display("ERROR at %0d ns: pdt_res_o expected %b actual %b",
                         $time, exp_res_i, act_res_i);
                ok = 1'b0;
            end
            if (act_pc_i !== exp_pc_i) begin
                $display("ERROR at %0d ns: pdt_pc_o expected %08h actual %08h",
                         $time, exp_pc_i, act_pc_i);
                ok = 1'b0;
            end
            if (ok) begin
                n_pass = n_pass + 1;
                $display("row %0d pass", row_i);
            end else begin
                n_fail = n_fail + 1;
                $display("row %0d fail", row_i);
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2) clk_o = ~clk_o;
    end

    // released on a falling edge, clear of the flops' sampling edge
    initial begin
        rst_o = 1'b1;
        #(reset_cycles * period_ns);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/bpu.sv
`timescale 1ns/1ps
`default_nettype none

module bpu (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::xlen-1:0] if_pc_i,
    input  logic [bpu_pkg::xlen-1:0] if_inst_i,
    input  logic                     ex_branch_valid_i,
    input  logic                     ex_branch_taken_i,
    input  logic [bpu_pkg::xlen-1:0] ex_pc_i,
    input  logic [bpu_pkg::xlen-1:0] ex_target_i,
    input  logic [bpu_pkg::xlen-1:0] ex_inst_i,
    input  logic                     id_ras_push_valid_i,
    input  logic [bpu_pkg::xlen-1:0] id_ras_push_data_i,
    input  logic                     ex_stall_valid_i,
    output logic                     branch_or_not_o,
    output logic [bpu_pkg::xlen-1:0] pdt_pc_o,
    output logic                     pdt_res_o
);
    import bpu_pkg::*;

    logic            if_is_branch, if_is_jal, if_is_jalr, if_is_ret;
    logic [xlen-1:0] if_b_imm, if_j_imm;
    logic            ex_is_ret;
    logic            ras_pop;
    logic            bht_taken;
    logic            btb_hit;
    logic [xlen-1:0] btb_target;
    logic            ras_valid;
    logic [xlen-1:0] ras_top;

    bpu_update_if upd_if ();

    assign upd_if.valid  = ex_branch_valid_i;
    assign upd_if.taken  = ex_branch_taken_i;
    assign upd_if.pc     = ex_pc_i;
    assign upd_if.target = ex_target_i;

    inst_predecode u_if_predecode (
        .inst_i      (if_inst_i),
        .is_branch_o (if_is_branch),
        .is_jal_o    (if_is_jal),
        .is_jalr_o   (if_is_jalr),
        .is_ret_o    (if_is_ret),
        .b_imm_o     (if_b_imm),
        .j_imm_o     (if_j_imm)
    );

    // only the return flag matters on the ex side
    inst_predecode u_ex_predecode (
        .inst_i      (ex_inst_i),
        .is_branch_o (),
        .is_jal_o    (),
        .is_jalr_o   (),
        .is_ret_o    (ex_is_ret),
        .b_imm_o     (),
        .j_imm_o     ()
    );

    assign ras_pop = ex_branch_valid_i && ex_branch_taken_i && ex_is_ret;

    bimodal_table u_bht (
        .clk     (clk),
        .rst     (rst),
        .pc_i    (if_pc_i),
        .upd     (upd_if.tbl),
        .taken_o (bht_taken)
    );

    btb u_btb (
        .clk      (clk),
        .rst      (rst),
        .pc_i     (if_pc_i),
        .upd      (upd_if.tbl),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

    return_stack u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (id_ras_push_valid_i),
        .push_data_i (id_ras_push_data_i),
        .pop_i       (ras_pop),
        .stall_i     (ex_stall_valid_i),
        .valid_o     (ras_valid),
        .top_o       (ras_top)
    );

    next_pc_select u_sel (
        .pc_i            (if_pc_i),
        .is_branch_i     (if_is_branch),
        .is_jal_i        (if_is_jal),
        .is_jalr_i       (if_is_jalr),
        .is_ret_i        (if_is_ret),
        .b_imm_i         (if_b_imm),
        .j_imm_i         (if_j_imm),
        .bht_taken_i     (bht_taken),
        .btb_hit_i       (btb_hit),
        .btb_target_i    (btb_target),
        .ras_valid_i     (ras_valid),
        .ras_top_i       (ras_top),
        .branch_or_not_o (branch_or_not_o),
        .pdt_res_o       (pdt_res_o),
        .pdt_pc_o        (pdt_pc_o)
    );

endmodule

`default_nettype wire

//--- hdl/next_pc_select.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc_select (
    input  logic [bpu_pkg::xlen-1:0] pc_i,
    input  logic                     is_branch_i,
    input  logic                     is_jal_i,
    input  logic                     is_jalr_i,
    input  logic                     is_ret_i,
    input  logic [bpu_pkg::xlen-1:0] b_imm_i,
    input  logic [bpu_pkg::xlen-1:0] j_imm_i,
    input  logic                     bht_taken_i,
    input  logic                     btb_hit_i,
    input  logic [bpu_pkg::xlen-1:0] btb_target_i,
    input  logic                     ras_valid_i,
    input  logic [bpu_pkg::xlen-1:0] ras_top_i,
    output logic                     branch_or_not_o,
    output logic                     pdt_res_o,
    output logic [bpu_pkg::xlen-1:0] pdt_pc_o
);
    import bpu_pkg::*;

    logic [xlen-1:0] seq_pc;

    assign seq_pc = pc_i + xlen'(4);

    assign branch_or_not_o = is_branch_i || is_jal_i || is_jalr_i;

    always_comb begin
        pdt_res_o = 1'b0;
        pdt_pc_o  = seq_pc;

        if (is_ret_i) begin
            // empty stack falls through
            if (ras_valid_i) begin
                pdt_res_o = 1'b1;
                pdt_pc_o  = ras_top_i;
            end
        end else if (is_jal_i) begin
            pdt_res_o = 1'b1;   // unconditional
            pdt_pc_o  = btb_hit_i ? btb_target_i : pc_i + j_imm_i;
        end else if (is_branch_i || is_jalr_i) begin
            pdt_res_o = bht_taken_i;
            if (bht_taken_i) begin
                if (btb_hit_i) begin
                    pdt_pc_o = btb_target_i;
                end else if (is_branch_i) begin
                    pdt_pc_o = pc_i + b_imm_i;
                end
                // indirect jalr with no btb entry keeps seq_pc
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/return_stack.sv
`timescale 1ns/1ps
`default_nettype none

module return_stack (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push_i,
    input  logic [bpu_pkg::xlen-1:0] push_data_i,
    input  logic                     pop_i,
    input  logic                     stall_i,
    output logic                     valid_o,
    output logic [bpu_pkg::xlen-1:0] top_o
);
    import bpu_pkg::*;

    logic [xlen-1:0]      stack_q [ras_depth];
    logic [ras_cnt_w-1:0] cnt_q;      // number of live entries
    logic [ras_cnt_w-1:0] cnt_pop;    // count after the pop
    logic [ras_cnt_w-2:0] top_idx;
    logic                 do_pop;
    logic                 do_push;

    // pop first, then push into the freed slot
    assign do_pop  = pop_i && !stall_i && (cnt_q != '0);
    assign cnt_pop = do_pop ? cnt_q - ras_cnt_w'(1) : cnt_q;
    assign do_push = push_i && !stall_i && (cnt_pop < ras_cnt_w'(ras_depth));  // full drops

    // wraps to the last slot when empty, masked by valid_o
    assign top_idx = cnt_q[ras_cnt_w-2:0] - 1'b1;

    assign valid_o = (cnt_q != '0);
    assign top_o   = stack_q[top_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_pop + {{(ras_cnt_w-1){1'b0}}, do_push};
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[cnt_pop[ras_cnt_w-2:0]] <= push_data_i;
        end
    end

    a_cnt_bound : assert property (
        @(posedge clk) disable iff (rst) cnt_q <= ras_cnt_w'(ras_depth)
    ) else $error("ras: occupancy above depth");

endmodule

`default_nettype wire

//--- hdl/btb.sv
`timescale 1ns/1ps
`default_nettype none

module btb (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::xlen-1:0] pc_i,
    bpu_update_if.tbl                upd,
    output logic                     hit_o,
    output logic [bpu_pkg::xlen-1:0] target_o
);
    import bpu_pkg::*;

    logic [btb_tag_w-1:0]   tag_q    [btb_entries];
    logic [xlen-1:0]        target_q [btb_entries];
    logic [btb_entries-1:0] valid_q;

    logic [btb_idx_w-1:0]   rd_idx;
    logic [btb_tag_w-1:0]   rd_tag;
    logic [btb_idx_w-1:0]   wr_idx;
    logic [btb_tag_w-1:0]   wr_tag;
    logic                   fill;

    assign rd_idx = pc_i[btb_idx_w+1:2];
    assign rd_tag = pc_i[xlen-1:xlen-btb_tag_w];
    assign wr_idx = upd.pc[btb_idx_w+1:2];
    assign wr_tag = upd.pc[xlen-1:xlen-btb_tag_w];

    assign fill = upd.valid && upd.taken;   // only taken branches allocate

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= upd.target;
        end
    end

    a_hit_known : assert property (
        @(posedge clk) disable iff (rst) hit_o |-> !$isunknown(target_o)
    ) else $error("btb: hit with unknown target");

endmodule

`default_nettype wire

//--- hdl/bimodal_table.sv
`timescale 1ns/1ps
`default_nettype none

module bimodal_table (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::xlen-1:0] pc_i,
    bpu_update_if.tbl                upd,
    output logic                     taken_o
);
    import bpu_pkg::*;

    ctr_t                 ctr_q [bht_entries];
    logic [bht_idx_w-1:0] rd_idx;
    logic [bht_idx_w-1:0] wr_idx;
    ctr_t                 wr_ctr;

    assign rd_idx = pc_i[bht_idx_w:1];    // halfword granularity
    assign wr_idx = upd.pc[bht_idx_w:1];
    assign wr_ctr = ctr_q[wr_idx];

    assign taken_o = ctr_q[rd_idx][1];    // msb gives the direction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bht_entries; i++) begin
                ctr_q[i] <= ctr_weak_nt;
            end
        end else if (upd.valid) begin
            if (upd.taken) begin
                if (wr_ctr != 2'b11) begin
                    ctr_q[wr_idx] <= wr_ctr + 2'd1;
                end
            end else begin
                if (wr_ctr != 2'b00) begin
                    ctr_q[wr_idx] <= wr_ctr - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/inst_predecode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_predecode (
    input  bpu_pkg::inst_word_u      inst_i,
    output logic                     is_branch_o,
    output logic                     is_jal_o,
    output logic                     is_jalr_o,
    output logic                     is_ret_o,
    output logic [bpu_pkg::xlen-1:0] b_imm_o,
    output logic [bpu_pkg::xlen-1:0] j_imm_o
);
    import bpu_pkg::*;

    logic [11:0] i_imm;     // bits 31:20 as an i-type immediate
    logic        link_src;  // rs1 is ra or t0

    assign is_branch_o = (inst_i.b.opcode == op_branch);
    assign is_jal_o    = (inst_i.b.opcode == op_jal);
    assign is_jalr_o   = (inst_i.b.opcode == op_jalr);

    assign i_imm    = {inst_i.j.imm20, inst_i.j.imm10_1, inst_i.j.imm11};
    assign link_src = (inst_i.b.rs1 == reg_ra) || (inst_i.b.rs1 == reg_t0);

    // jalr x0, 0(ra|t0)
    assign is_ret_o = is_jalr_o && (inst_i.j.rd == 5'd0) && link_src && (i_imm == 12'd0);

    // sign-extended offsets, bit 0 always zero
    assign b_imm_o = {{20{inst_i.b.imm12}}, inst_i.b.imm11, inst_i.b.imm10_5,
                      inst_i.b.imm4_1, 1'b0};
    assign j_imm_o = {{12{inst_i.j.imm20}}, inst_i.j.imm19_12, inst_i.j.imm11,
                      inst_i.j.imm10_1, 1'b0};

endmodule

`default_nettype wire

//--- hdl/bpu_update_if.sv
`timescale 1ns/1ps
`default_nettype none

// one resolved branch from EX, consumed in the cycle valid is high
interface bpu_update_if;
    import bpu_pkg::*;

    logic            valid;
    logic            taken;   // actual direction
    logic [xlen-1:0] pc;      // pc of the resolved branch
    logic [xlen-1:0] target;  // actual target

    modport src (
        output valid, taken, pc, target
    );

    modport tbl (
        input valid, taken, pc, target
    );

endinterface

`default_nettype wire

//--- hdl/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    localparam int xlen        = 32;

    // bimodal table, indexed by pc[9:1]
    localparam int bht_entries = 512;
    localparam int bht_idx_w   = 9;

    // btb, indexed by pc[9:2], tagged by pc[31:10]
    localparam int btb_entries = 256;
    localparam int btb_idx_w   = 8;
    localparam int btb_tag_w   = 22;

    localparam int ras_depth   = 32;
    localparam int ras_cnt_w   = 6;   // holds 0..32

    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    localparam logic [4:0] reg_ra = 5'd1;
    localparam logic [4:0] reg_t0 = 5'd5;

    typedef logic [1:0] ctr_t;   // 2-bit saturating counter

    localparam ctr_t ctr_weak_nt = 2'b01;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // upper 12 bits {imm20, imm10_1, imm11} double as the i-type imm12
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        b_fmt_t b;
        j_fmt_t j;
    } inst_word_u;

endpackage

`default_nettype wire
